// File: Bender.yml
package:
  name: if_stage

sources:
  # fetch stage RTL, package first
  - files:
      - src/if_pkg.sv
      - src/if_pc_select.sv
      - src/if_fetch_ctrl.sv
      - src/if_fetch_fifo.sv
      - src/if_id_reg.sv
      - src/if_stage.sv

  # testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_if_stage.sv

// File: list.f
+incdir+test
src/if_pkg.sv
src/if_pc_select.sv
src/if_fetch_ctrl.sv
src/if_fetch_fifo.sv
src/if_id_reg.sv
src/if_stage.sv
test/tb_if_stage.sv

// File: src/if_fetch_ctrl.sv
// instruction bus requester
// issues word fetches, tracks grants in flight and drops responses to a stale path

`timescale 1ns/1ps

module if_fetch_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  if_pkg::redirect_t             redirect_i,

  // instruction bus
  output logic                          instr_req_o,
  output logic [if_pkg::xlen-1:0]       instr_addr_o,
  input  logic                          instr_gnt_i,
  input  logic                          instr_rvalid_i,
  input  logic [if_pkg::xlen-1:0]       instr_rdata_i,
  input  logic                          instr_bus_err_i,

  // fetch FIFO side
  input  logic [if_pkg::fifo_cnt_w-1:0] fifo_count_i,
  output logic                          push_o,
  output if_pkg::fetch_entry_t          push_entry_o,
  output logic                          flush_o,
  output logic                          busy_o
);

  import if_pkg::*;

  logic                active_q;
  logic [xlen-1:0]     addr_q;
  logic [oq_cnt_w-1:0] outstanding_q;
  logic [oq_cnt_w-1:0] outstanding_d;
  logic [oq_cnt_w-1:0] discard_q;
  logic [oq_cnt_w-1:0] discard_d;
  logic [oq_ptr_w-1:0] oq_wr_q;
  logic [oq_ptr_w-1:0] oq_rd_q;
  logic [xlen-1:0]     oq_addr_q [max_outstanding];
  logic [fifo_cnt_w:0] in_use;
  logic                room;
  logic                gnt_fire;
  logic                drop;

  // wrap for the response address queue
  function automatic logic [oq_ptr_w-1:0] oq_ptr_inc(input logic [oq_ptr_w-1:0] ptr);
    if (ptr == oq_ptr_w'(max_outstanding - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  // slots already claimed: words in flight plus words buffered
  assign in_use = outstanding_q + fifo_count_i;
  // back-pressure, never ask for more than the FIFO can take
  assign room   = (outstanding_q < max_outstanding) & (in_use < fifo_depth);

  // nothing goes out before the first PC set
  assign instr_req_o  = active_q & room;
  assign instr_addr_o = addr_q;
  assign gnt_fire     = instr_req_o & instr_gnt_i;

  //////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////

  // responses to the old path are still owed
  assign drop = (discard_q != '0);

  assign push_o             = instr_rvalid_i & ~drop;
  assign push_entry_o.addr  = oq_addr_q[oq_rd_q];
  assign push_entry_o.rdata = instr_rdata_i;
  assign push_entry_o.err   = instr_bus_err_i;

  assign flush_o = redirect_i.set;
  assign busy_o  = (outstanding_q != '0);

  assign outstanding_d = outstanding_q + oq_cnt_w'(gnt_fire) - oq_cnt_w'(instr_rvalid_i);

  always_comb begin
    discard_d = discard_q;
    if (redirect_i.set) begin
      // everything still in flight, incl. a grant this cycle, is stale
      discard_d = outstanding_d;
    end else if (instr_rvalid_i && drop) begin
      discard_d = discard_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q      <= 1'b0;
      addr_q        <= '0;
      outstanding_q <= '0;
      discard_q     <= '0;
      oq_wr_q       <= '0;
      oq_rd_q       <= '0;
    end else begin
      outstanding_q <= outstanding_d;
      discard_q     <= discard_d;
      if (redirect_i.set) begin
        active_q <= 1'b1;
        addr_q   <= redirect_i.target;
      end else if (gnt_fire) begin
        addr_q <= addr_q + xlen'(4);
      end
      // queue stays in step with the bus, stale entries included
      if (gnt_fire) begin
        oq_wr_q <= oq_ptr_inc(oq_wr_q);
      end
      if (instr_rvalid_i) begin
        oq_rd_q <= oq_ptr_inc(oq_rd_q);
      end
    end
  end

  // address of each granted word, read back in order
  always_ff @(posedge clk_i) begin
    if (gnt_fire) begin
      oq_addr_q[oq_wr_q] <= addr_q;
    end
  end

endmodule

// File: src/if_fetch_fifo.sv
// fetch FIFO
// circular buffer of returned words, emptied in one edge on a PC set

`timescale 1ns/1ps

module if_fetch_fifo (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  // write side
  input  logic                          push_i,
  input  if_pkg::fetch_entry_t          push_entry_i,
  input  logic                          flush_i,

  // read side
  input  logic                          pop_i,
  output logic                          valid_o,
  output if_pkg::fetch_entry_t          entry_o,

  // occupancy for the requester
  output logic [if_pkg::fifo_cnt_w-1:0] count_o
);

  import if_pkg::*;

  logic [fifo_ptr_w-1:0] rd_ptr_q;
  logic [fifo_ptr_w-1:0] wr_ptr_q;
  logic [fifo_cnt_w-1:0] count_q;
  fetch_entry_t          mem_q [fifo_depth];
  logic                  push_ok;
  logic                  pop_ok;

  // depth is not a power of two, wrap by hand
  function automatic logic [fifo_ptr_w-1:0] ptr_inc(input logic [fifo_ptr_w-1:0] ptr);
    if (ptr == fifo_ptr_w'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  assign valid_o = (count_q != '0);
  assign entry_o = mem_q[rd_ptr_q];
  assign count_o = count_q;

  // flush beats both ends
  assign pop_ok  = pop_i & valid_o & ~flush_i;
  // full FIFO only takes a word when one leaves
  assign push_ok = push_i & ~flush_i & ((count_q < fifo_depth) | pop_ok);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_ok) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // occupancy moves only when exactly one side fires
      unique case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

endmodule

// File: src/if_id_reg.sv
// IF-ID pipeline register
// captures the head fetch word for decode and keeps the valid and new flags

`timescale 1ns/1ps

module if_id_reg (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // fetch FIFO head
  input  logic                    valid_i,
  input  if_pkg::fetch_entry_t    entry_i,
  output logic                    pop_o,

  input  logic                    pmp_err_if_i,
  input  logic                    pc_set_i,

  // decode side
  input  logic                    id_in_ready_i,
  input  logic                    instr_valid_clear_i,
  output if_pkg::id_instr_t       id_instr_o,
  output logic                    instr_valid_id_o,
  output logic                    instr_new_id_o,
  output logic [if_pkg::xlen-1:0] pc_if_o
);

  import if_pkg::*;

  logic      capture;
  logic      valid_q;
  logic      new_q;
  id_instr_t id_instr_q;

  // a PC set squashes the word at the head
  assign capture = valid_i & id_in_ready_i & ~pc_set_i;
  assign pop_o   = capture;

  // address of the word waiting in IF, checked by the PMP
  assign pc_if_o = entry_i.addr;

  //////////////////////////////////////////////////
  // flags
  //////////////////////////////////////////////////

  // valid holds until decode clears it, a new capture wins
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= capture | (valid_q & ~instr_valid_clear_i);
      // one-cycle marker per captured word
      new_q   <= capture;
    end
  end

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////

  // frozen while decode stalls
  always_ff @(posedge clk_i) begin
    if (capture) begin
      id_instr_q.instr     <= entry_i.rdata;
      id_instr_q.pc_id     <= entry_i.addr;
      // bus and PMP faults look the same to decode
      id_instr_q.fetch_err <= entry_i.err | pmp_err_if_i;
    end
  end

  assign id_instr_o       = id_instr_q;
  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

// File: src/if_pc_select.sv
// next-PC select for the fetch stage
// computes exception vectors and picks boot, jump, trap or return targets

`timescale 1ns/1ps

module if_pc_select (
  // address sources
  input  logic [if_pkg::xlen-1:0] boot_addr_i,
  input  logic [if_pkg::xlen-1:0] branch_target_ex_i,
  input  logic [if_pkg::xlen-1:0] csr_mepc_i,
  input  logic [if_pkg::xlen-1:0] csr_depc_i,
  input  logic [if_pkg::xlen-1:0] csr_mtvec_i,

  // control from the controller
  input  logic                    pc_set_i,
  input  if_pkg::pc_sel_e         pc_mux_i,
  input  if_pkg::exc_pc_sel_e     exc_pc_mux_i,
  input  if_pkg::exc_cause_t      exc_cause_i,

  output if_pkg::redirect_t       redirect_o,
  output logic                    csr_mtvec_init_o
);

  import if_pkg::*;

  logic [4:0]      irq_vec;
  logic [xlen-1:0] exc_pc;
  logic [xlen-1:0] next_pc;

  // vector slot for interrupts
  always_comb begin
    irq_vec = exc_cause_i.lower_cause;
    // internal sources never use their own slot
    if (exc_cause_i.irq_int) begin
      irq_vec = nmi_vector;
    end
  end

  //////////////////////////////////////////////////
  // exception PC
  //////////////////////////////////////////////////

  // mtvec low byte is ignored, so base + vec*4 is a plain concat
  always_comb begin
    exc_pc = {csr_mtvec_i[xlen-1:8], 8'h00};
    unique case (exc_pc_mux_i)
      exc_pc_exc:     exc_pc = {csr_mtvec_i[xlen-1:8], 8'h00};
      exc_pc_irq:     exc_pc = {csr_mtvec_i[xlen-1:8], 1'b0, irq_vec, 2'b00};
      exc_pc_dbd:     exc_pc = dm_halt_addr;
      exc_pc_dbg_exc: exc_pc = dm_exception_addr;
      default:        exc_pc = {csr_mtvec_i[xlen-1:8], 8'h00};
    endcase
  end

  //////////////////////////////////////////////////
  // next PC
  //////////////////////////////////////////////////

  always_comb begin
    next_pc = {boot_addr_i[xlen-1:8], boot_offset};
    unique case (pc_mux_i)
      pc_boot: next_pc = {boot_addr_i[xlen-1:8], boot_offset};
      pc_jump: next_pc = branch_target_ex_i;
      // trap entry
      pc_exc:  next_pc = exc_pc;
      // return from trap
      pc_eret: next_pc = csr_mepc_i;
      // return from debug mode
      pc_dret: next_pc = csr_depc_i;
      default: next_pc = {boot_addr_i[xlen-1:8], boot_offset};
    endcase
  end

  // every fetch is one aligned word
  assign redirect_o.set    = pc_set_i;
  assign redirect_o.target = {next_pc[xlen-1:2], 2'b00};

  // CSR file loads mtvec from the boot address on boot
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == pc_boot);

endmodule

// File: src/if_pkg.sv
// fetch stage shared definitions
// constants, selector encodings and the structs passed between the fetch blocks

package if_pkg;

  //////////////////////////////////////////////////
  // constants
  //////////////////////////////////////////////////

  // address and instruction word width
  localparam int unsigned xlen = 32;

  // boot entry sits at this offset above the 256-byte aligned boot base
  localparam logic [7:0] boot_offset = 8'h80;

  // debug module entry points
  localparam logic [xlen-1:0] dm_halt_addr      = 32'h1a11_0800;
  localparam logic [xlen-1:0] dm_exception_addr = 32'h1a11_0808;

  // fetch FIFO sizing
  localparam int unsigned fifo_depth = 3;
  localparam int unsigned fifo_ptr_w = $clog2(fifo_depth);
  localparam int unsigned fifo_cnt_w = $clog2(fifo_depth + 1);

  // granted but unanswered bus requests
  localparam int unsigned max_outstanding = 2;
  localparam int unsigned oq_ptr_w        = $clog2(max_outstanding);
  localparam int unsigned oq_cnt_w        = $clog2(max_outstanding + 1);

  // internal interrupts all land in the NMI slot
  localparam logic [4:0] nmi_vector = 5'd31;

  //////////////////////////////////////////////////
  // selectors
  //////////////////////////////////////////////////

  // next PC source
  typedef enum logic [2:0] {
    pc_boot,
    pc_jump,
    pc_exc,
    pc_eret,
    pc_dret
  } pc_sel_e;

  // exception PC source
  typedef enum logic [1:0] {
    exc_pc_exc,
    exc_pc_irq,
    exc_pc_dbd,
    exc_pc_dbg_exc
  } exc_pc_sel_e;

  //////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic       irq_int;
    logic       irq_ext;
    logic [4:0] lower_cause;
  } exc_cause_t;

  // PC set command from the select logic to the requester
  typedef struct packed {
    logic            set;
    logic [xlen-1:0] target;
  } redirect_t;

  // one returned bus word together with its address
  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] rdata;
    logic            err;
  } fetch_entry_t;

  // instruction as seen by decode
  typedef struct packed {
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc_id;
    logic            fetch_err;
  } id_instr_t;

endpackage

// File: src/if_stage.sv
// instruction fetch stage
// PC select, bus requester, fetch FIFO and IF-ID register

`timescale 1ns/1ps

module if_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // PC sources
  input  logic [if_pkg::xlen-1:0] boot_addr_i,
  input  logic [if_pkg::xlen-1:0] branch_target_ex_i,
  input  logic [if_pkg::xlen-1:0] csr_mepc_i,
  input  logic [if_pkg::xlen-1:0] csr_depc_i,
  input  logic [if_pkg::xlen-1:0] csr_mtvec_i,
  output logic                    csr_mtvec_init_o,

  // PC set control
  input  logic                    pc_set_i,
  input  if_pkg::pc_sel_e         pc_mux_i,
  input  if_pkg::exc_pc_sel_e     exc_pc_mux_i,
  input  if_pkg::exc_cause_t      exc_cause_i,

  // instruction bus
  output logic                    instr_req_o,
  output logic [if_pkg::xlen-1:0] instr_addr_o,
  input  logic                    instr_gnt_i,
  input  logic                    instr_rvalid_i,
  input  logic [if_pkg::xlen-1:0] instr_rdata_i,
  input  logic                    instr_bus_err_i,

  // decode side
  input  logic                    pmp_err_if_i,
  input  logic                    id_in_ready_i,
  input  logic                    instr_valid_clear_i,
  output if_pkg::id_instr_t       id_instr_o,
  output logic                    instr_valid_id_o,
  output logic                    instr_new_id_o,
  output logic [if_pkg::xlen-1:0] pc_if_o,

  output logic                    if_busy_o
);

  import if_pkg::*;

  redirect_t             redirect;
  fetch_entry_t          push_entry;
  fetch_entry_t          head_entry;
  logic                  fifo_push;
  logic                  fifo_flush;
  logic                  fifo_pop;
  logic                  fifo_valid;
  logic [fifo_cnt_w-1:0] fifo_count;

  if_pc_select u_pc_select (
    .boot_addr_i        (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .exc_cause_i        (exc_cause_i),
    .redirect_o         (redirect),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  // producer
  if_fetch_ctrl u_fetch_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .redirect_i      (redirect),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i),
    .fifo_count_i    (fifo_count),
    .push_o          (fifo_push),
    .push_entry_o    (push_entry),
    .flush_o         (fifo_flush),
    .busy_o          (if_busy_o)
  );

  if_fetch_fifo u_fetch_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (fifo_push),
    .push_entry_i (push_entry),
    .flush_i      (fifo_flush),
    .pop_i        (fifo_pop),
    .valid_o      (fifo_valid),
    .entry_o      (head_entry),
    .count_o      (fifo_count)
  );

  // consumer
  if_id_reg u_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .valid_i             (fifo_valid),
    .entry_i             (head_entry),
    .pop_o               (fifo_pop),
    .pmp_err_if_i        (pmp_err_if_i),
    .pc_set_i            (pc_set_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .id_instr_o          (id_instr_o),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .pc_if_o             (pc_if_o)
  );

endmodule

// File: test/tb_if_ref.svh
// reference model for the fetch stage testbench
// memory contents, entry-address rules, random source and result compares

`ifndef TB_IF_REF_SVH
`define TB_IF_REF_SVH

// memory word at a byte address
function automatic logic [31:0] mem_word(input logic [31:0] addr);
  return addr ^ 32'h9e37_79b9;
endfunction

// bus error window covers one 16-byte slice of every 128 bytes
function automatic logic mem_err(input logic [31:0] addr);
  return addr[6:4] == 3'd5;
endfunction

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// trap entry with vectored slots 4 bytes apart above the handler base
function automatic logic [31:0] exc_entry(input exc_pc_sel_e sel, input exc_cause_t cause);
  logic [31:0] base;
  logic [31:0] vec;
  base = csr_mtvec_i & 32'hffff_ff00;
  vec  = cause.irq_int ? {27'd0, nmi_vector} : {27'd0, cause.lower_cause};
  case (sel)
    exc_pc_exc: return base;
    exc_pc_irq: return base + vec * 4;
    exc_pc_dbd: return dm_halt_addr;
    default:    return dm_exception_addr;
  endcase
endfunction

// address the stream restarts at after a PC set
function automatic logic [31:0] pc_target(input pc_sel_e mux, input exc_pc_sel_e sel,
                                          input exc_cause_t cause);
  logic [31:0] t;
  case (mux)
    pc_boot: t = (boot_addr_i & 32'hffff_ff00) + 32'h80;
    pc_jump: t = branch_target_ex_i;
    pc_exc:  t = exc_entry(sel, cause);
    pc_eret: t = csr_mepc_i;
    default: t = csr_depc_i;
  endcase
  // fetch is word aligned
  return t & 32'hffff_fffc;
endfunction

task automatic check_instr(input string name, input id_instr_t exp, input id_instr_t act);
  if (act !== exp) begin
    instr_errs++;
    $display("Mismatch %s: expected instr %h pc %h err %b, actual instr %h pc %h err %b",
             name, exp.instr, exp.pc_id, exp.fetch_err,
             act.instr, act.pc_id, act.fetch_err);
  end
endtask

task automatic check_addr(input string name, input logic [xlen-1:0] exp,
                          input logic [xlen-1:0] act);
  if (act !== exp) begin
    addr_errs++;
    $display("Mismatch %s: expected pc_if %h, actual %h", name, exp, act);
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    bit_errs++;
    $display("Mismatch %s: expected %b, actual %b", name, exp, act);
  end
endtask

task automatic check_count(input string name, input int exp, input int act);
  if (act != exp) begin
    count_errs++;
    $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
  end
endtask

`endif

// File: test/tb_if_stage.sv
// testbench for the instruction fetch stage
// random-latency bus memory, random decode stalls, checks every captured word

`timescale 1ns/1ps

module tb_if_stage;

  import if_pkg::*;

  // 6 tests of 80 words with 12 cycles allowed per word
  localparam int timeout_cycles = 6 * 80 * 12;

  logic              clk_i;
  logic              rst_ni;
  logic [31:0]       boot_addr_i;
  logic [31:0]       branch_target_ex_i;
  logic [31:0]       csr_mepc_i;
  logic [31:0]       csr_depc_i;
  logic [31:0]       csr_mtvec_i;
  logic              csr_mtvec_init_o;
  logic              pc_set_i;
  pc_sel_e           pc_mux_i;
  exc_pc_sel_e       exc_pc_mux_i;
  exc_cause_t        exc_cause_i;
  logic              instr_req_o;
  logic [31:0]       instr_addr_o;
  logic              instr_gnt_i;
  logic              instr_rvalid_i;
  logic [31:0]       instr_rdata_i;
  logic              instr_bus_err_i;
  logic              pmp_err_if_i;
  logic              id_in_ready_i;
  logic              instr_valid_clear_i;
  id_instr_t         id_instr_o;
  logic              instr_valid_id_o;
  logic              instr_new_id_o;
  logic [31:0]       pc_if_o;
  logic              if_busy_o;

  int                instr_errs = 0;
  int                addr_errs = 0;
  int                bit_errs = 0;
  int                count_errs = 0;
  int                other_errs = 0;

  // environment state
  logic [31:0]       rnd_state = 32'h7184;
  logic [1:0]        ready_mode = 2'd2;  // 0 stalled, 1 always ready, 2 random
  logic [31:0]       rsp_addr_q [$];
  int                rsp_due_q [$];
  int                env_cyc;
  int                last_due;
  int                due;

  // checker state
  string             test_name = "reset";
  int                cyc;
  int                n_captured = 0;
  int                mtvec_pulses = 0;
  int                bus_pending;
  logic [31:0]       exp_pc;
  logic              pmp_last;
  logic [31:0]       pc_if_last;
  id_instr_t         exp_instr;
  // CSR init strobe follows the kind of PC set being issued
  logic              exp_mtvec_init = 1'b0;

  `include "tb_if_ref.svh"

  if_stage uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // bus memory and decode-side random inputs
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      instr_gnt_i     <= 1'b0;
      instr_rvalid_i  <= 1'b0;
      id_in_ready_i   <= 1'b0;
      pmp_err_if_i    <= 1'b0;
      rsp_addr_q.delete();
      rsp_due_q.delete();
      env_cyc  = 0;
      last_due = 0;
    end else begin
      env_cyc   = env_cyc + 1;
      rnd_state = xorshift(rnd_state);
      // answer the grant of the cycle that just ended 1 to 3 cycles on and in order
      if (instr_req_o && instr_gnt_i) begin
        due = env_cyc + int'(rnd_state[9:8] % 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_addr_q.push_back(instr_addr_o);
        rsp_due_q.push_back(due);
      end
      instr_gnt_i     <= (rnd_state[1:0] != 2'b00);
      instr_rvalid_i  <= 1'b0;
      instr_rdata_i   <= '0;
      instr_bus_err_i <= 1'b0;
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= env_cyc) begin
        instr_rvalid_i  <= 1'b1;
        instr_rdata_i   <= mem_word(rsp_addr_q[0]);
        instr_bus_err_i <= mem_err(rsp_addr_q[0]);
        void'(rsp_addr_q.pop_front());
        void'(rsp_due_q.pop_front());
      end
      case (ready_mode)
        2'd0:    id_in_ready_i <= 1'b0;
        2'd1:    id_in_ready_i <= 1'b1;
        default: id_in_ready_i <= rnd_state[3];
      endcase
      pmp_err_if_i <= (rnd_state[7:5] == 3'd0);
    end
  end

  //////////////////////////////////////////////////
  // comparison
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      cyc         = 0;
      pmp_last    = 1'b0;
      pc_if_last  = '0;
      bus_pending = 0;
    end else if (cyc >= timeout_cycles) begin
      other_errs++;
      $display("timeout: test %s still running after %0d cycles", test_name, cyc);
      close_run();
    end else begin
      cyc = cyc + 1;
      // word captured at the previous edge with PMP and head address sampled there
      if (instr_new_id_o) begin
        exp_instr.instr     = mem_word(exp_pc);
        exp_instr.pc_id     = exp_pc;
        exp_instr.fetch_err = mem_err(exp_pc) | pmp_last;
        check_instr(test_name, exp_instr, id_instr_o);
        check_addr(test_name, exp_pc, pc_if_last);
        exp_pc     = exp_pc + 32'd4;
        n_captured <= n_captured + 1;
      end
      pmp_last   = pmp_err_if_i;
      pc_if_last = pc_if_o;
      // granted words not yet answered on the bus
      check_bit("busy", bus_pending != 0, if_busy_o);
      if (instr_req_o && instr_gnt_i) begin
        bus_pending++;
      end
      if (instr_rvalid_i) begin
        bus_pending--;
      end
      check_bit("mtvec_init", exp_mtvec_init, csr_mtvec_init_o);
      if (csr_mtvec_init_o) begin
        mtvec_pulses++;
      end
      // stream restarts here
      if (pc_set_i) begin
        exp_pc = pc_target(pc_mux_i, exc_pc_mux_i, exc_cause_i);
      end
    end
  end

  task automatic close_run();
    $display("error counts: %0d instr, %0d addr, %0d flag, %0d count, %0d other",
             instr_errs, addr_errs, bit_errs, count_errs, other_errs);
    if (instr_errs + addr_errs + bit_errs + count_errs + other_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // one-cycle PC set
  task automatic set_pc(input pc_sel_e mux, input exc_pc_sel_e sel, input exc_cause_t cause);
    @(posedge clk_i);
    pc_set_i       <= 1'b1;
    pc_mux_i       <= mux;
    exc_pc_mux_i   <= sel;
    exc_cause_i    <= cause;
    exp_mtvec_init <= (mux == pc_boot);
    @(posedge clk_i);
    pc_set_i       <= 1'b0;
    exp_mtvec_init <= 1'b0;
  endtask

  task automatic wait_instrs(input int n);
    int base;
    @(posedge clk_i);
    base = n_captured;
    while (n_captured < base + n) begin
      @(posedge clk_i);
    end
  endtask

  task automatic enter_trap(input string name, input exc_pc_sel_e sel, input exc_cause_t cause);
    test_name <= name;
    set_pc(pc_exc, sel, cause);
    wait_instrs(16);
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    rst_ni              = 1'b0;
    boot_addr_i         = 32'h0000_2345;
    branch_target_ex_i  = 32'h0000_4102;
    csr_mepc_i          = 32'h0000_6006;
    csr_depc_i          = 32'h0000_7ff8;
    csr_mtvec_i         = 32'h0000_8a5d;
    pc_set_i            = 1'b0;
    pc_mux_i            = pc_boot;
    exc_pc_mux_i        = exc_pc_exc;
    exc_cause_i         = '0;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    instr_bus_err_i     = 1'b0;
    pmp_err_if_i        = 1'b0;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    // quiet until the first PC set
    repeat (4) begin
      @(posedge clk_i);
      check_bit("idle_req", 1'b0, instr_req_o);
      check_bit("idle_busy", 1'b0, if_busy_o);
      check_bit("idle_valid", 1'b0, instr_valid_id_o);
      check_bit("idle_new", 1'b0, instr_new_id_o);
    end

    test_name <= "boot";
    set_pc(pc_boot, exc_pc_exc, '0);
    wait_instrs(80);

    // redirects while the old stream is still in flight
    test_name <= "jump";
    set_pc(pc_jump, exc_pc_exc, '0);
    wait_instrs(27);
    test_name <= "mret";
    set_pc(pc_eret, exc_pc_exc, '0);
    wait_instrs(27);
    test_name <= "dret";
    set_pc(pc_dret, exc_pc_exc, '0);
    wait_instrs(26);

    enter_trap("exc_handler", exc_pc_exc, '0);
    enter_trap("irq_ext", exc_pc_irq, {1'b0, 1'b1, 5'd7});
    enter_trap("irq_int_nmi", exc_pc_irq, {1'b1, 1'b0, 5'd3});
    enter_trap("debug_halt", exc_pc_dbd, '0);
    enter_trap("debug_exc", exc_pc_dbg_exc, '0);

    test_name <= "backpressure";
    @(posedge clk_i);
    branch_target_ex_i <= 32'h0000_c0f1;
    set_pc(pc_jump, exc_pc_exc, '0);
    wait_instrs(80);

    // starts inside the bus error window
    test_name <= "errors";
    @(posedge clk_i);
    csr_mepc_i <= 32'h0000_e050;
    set_pc(pc_eret, exc_pc_exc, '0);
    wait_instrs(80);

    test_name <= "valid_hold";
    set_pc(pc_dret, exc_pc_exc, '0);
    wait_instrs(1);
    ready_mode <= 2'd0;
    // let the last capture before the stall drain out
    repeat (3) @(posedge clk_i);
    repeat (5) begin
      @(posedge clk_i);
      check_bit("valid_hold", 1'b1, instr_valid_id_o);
      check_bit("no_new_stalled", 1'b0, instr_new_id_o);
    end
    @(posedge clk_i);
    instr_valid_clear_i <= 1'b1;
    @(posedge clk_i);
    instr_valid_clear_i <= 1'b0;
    @(posedge clk_i);
    check_bit("valid_clear", 1'b0, instr_valid_id_o);
    ready_mode <= 2'd2;
    wait_instrs(78);

    check_count("mtvec_pulses", 1, mtvec_pulses);
    close_run();
  end

endmodule
